//--- filelist.f
+incdir+src
src/MemCtrlPkg.sv
src/RequestLatch.sv
src/BurstSequencer.sv
src/CacheSram.sv
src/ExtBusDriver.sv
src/MemorySubsystem.sv
tests/ExtMemModel.sv
tests/MemorySubsystemTb.sv

//--- run.sh
#!/bin/sh
# Build and run the testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f filelist.f --top-module MemorySubsystemTb -o simv
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

out=$(./obj_dir/simv)
status=$?
echo "$out"
if [ $status -ne 0 ]; then
    echo "Simulator exited with status $status"
    exit 1
fi

if echo "$out" | grep -q "Simulation PASSED"; then
    exit 0
fi
exit 1

//--- tests/MemorySubsystemTb.sv
`timescale 1ns/1ns

module MemorySubsystemTb;

    localparam int NumPairs = 6;
    localparam int TimeoutCycles = NumPairs * (2 * 140 + 3 * 132) + 1000;

    logic        clk;
    logic        rst;
    logic        reqStrobe;
    logic        reqWrite;
    logic        reqCacheId;
    logic [9:0]  reqSramAddr;
    logic [29:0] reqExtAddr;
    logic        busy;
    logic [9:0]  progress;
    logic        extEn;
    logic        extOen;
    logic [31:0] extBusOut;
    logic [31:0] extBusIn;
    logic [9:0]  coreAddr0;
    logic [31:0] coreData0;
    logic [9:0]  coreAddr1;
    logic [31:0] coreData1;

    logic [31:0] lfsrState;
    logic [31:0] expMem [logic [29:0]];
    logic [31:0] shadow [0:1][0:1023];
    int          flowErrors;
    int          monErrors;
    int          cycleCount;
    int          expectedHeaders;

    // Request seen by the bus monitor
    logic        curWrite;
    logic        curCache;
    logic [29:0] curExt;
    logic        prevEn;
    logic        prevBusy;
    logic [9:0]  lastProg;
    logic [9:0]  peakProg;

    MemorySubsystem u_dut (
        .clk(clk), .rst(rst),
        .reqStrobe(reqStrobe), .reqWrite(reqWrite), .reqCacheId(reqCacheId),
        .reqSramAddr(reqSramAddr), .reqExtAddr(reqExtAddr),
        .busy(busy), .progress(progress),
        .extEn(extEn), .extOen(extOen), .extBusOut(extBusOut), .extBusIn(extBusIn),
        .coreAddr0(coreAddr0), .coreData0(coreData0),
        .coreAddr1(coreAddr1), .coreData1(coreData1)
    );

    ExtMemModel u_mem (
        .clk(clk), .extEn(extEn), .extOen(extOen),
        .extBusOut(extBusOut), .extBusIn(extBusIn)
    );

    function automatic logic [31:0] randBits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsrState = lfsrState[0] ? (lfsrState >> 1) ^ 32'hA3000000 : lfsrState >> 1;
            v = {v[30:0], lfsrState[0]};
        end
        return v;
    endfunction

    function automatic logic [31:0] patternWord(input logic [29:0] a);
        return {a, 2'b10} ^ {~a[13:0], a[29:12]};
    endfunction

    function automatic int refBurstLen(input logic cacheId);
        return cacheId ? 128 : 64;
    endfunction

    // Expected external word, written-back data overrides the preload
    function automatic logic [31:0] refWord(input logic [29:0] a);
        return expMem.exists(a) ? expMem[a] : patternWord(a);
    endfunction

    task automatic coreRead(input logic cache, input logic [9:0] addr,
                            output logic [31:0] data);
        @(posedge clk);
        if (cache) coreAddr1 <= addr;
        else coreAddr0 <= addr;
        @(posedge clk);
        @(negedge clk);
        data = cache ? coreData1 : coreData0;
    endtask

    task automatic runRequest(input logic write, input logic cache,
                              input logic [9:0] sAddr, input logic [29:0] eAddr);
        @(posedge clk);
        reqStrobe <= 1'b1;
        reqWrite <= write;
        reqCacheId <= cache;
        reqSramAddr <= sAddr;
        reqExtAddr <= eAddr;
        curWrite <= write;
        curCache <= cache;
        curExt <= eAddr;
        expectedHeaders++;
        @(posedge clk);
        reqStrobe <= 1'b0;
        do @(negedge clk); while (!busy);
        // Stray request in the middle of the burst
        repeat (5) @(posedge clk);
        reqStrobe <= 1'b1;
        reqWrite <= !write;
        reqCacheId <= !cache;
        reqExtAddr <= ~eAddr;
        @(posedge clk);
        reqStrobe <= 1'b0;
        do @(negedge clk); while (busy);
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount <= cycleCount + 1;
        if (cycleCount >= TimeoutCycles) begin
            $display("Timeout: run did not finish within %0d cycles", TimeoutCycles);
            $display("Errors: %0d in checks, %0d in monitor", flowErrors, monErrors);
            $display("Simulation FAILED");
            $finish;
        end
    end

    // Header and progress monitor
    always @(negedge clk) begin
        if (!rst) begin
            if (extEn && !prevEn && extBusOut !== {curWrite, curCache, curExt}) begin
                $display("FAIL %0t: header %h, expected %h", $time, extBusOut,
                         {curWrite, curCache, curExt});
                monErrors++;
            end
            if (busy && !prevBusy) begin
                lastProg = '0;
                peakProg = '0;
            end
            if (busy && !curWrite) begin
                if (progress < lastProg) begin
                    $display("FAIL %0t: progress fell from %0d to %0d", $time,
                             lastProg, progress);
                    monErrors++;
                end
                lastProg = progress;
                if (progress > peakProg) peakProg = progress;
            end
            if (!busy && prevBusy) begin
                if (progress != 0) begin
                    $display("FAIL %0t: progress %0d after busy fell", $time, progress);
                    monErrors++;
                end
                if (extEn !== 1'b0 || extOen !== 1'b1) begin
                    $display("FAIL %0t: bus not released when busy fell", $time);
                    monErrors++;
                end
                if (!curWrite && peakProg != 10'(refBurstLen(curCache))) begin
                    $display("FAIL %0t: progress peak %0d", $time, peakProg);
                    monErrors++;
                end
            end
            prevEn = extEn;
            prevBusy = busy;
        end
    end

    initial begin
        logic        cache;
        logic [9:0]  sAddr;
        logic [29:0] eA;
        logic [29:0] eB;
        logic [31:0] got;
        logic [31:0] before0;
        logic [31:0] before1;
        int          len;
        rst = 1'b1;
        reqStrobe = 1'b0;
        reqWrite = 1'b0;
        reqCacheId = 1'b0;
        reqSramAddr = '0;
        reqExtAddr = '0;
        coreAddr0 = '0;
        coreAddr1 = '0;
        lfsrState = 32'h700a;
        flowErrors = 0;
        monErrors = 0;
        cycleCount = 0;
        expectedHeaders = 0;
        curWrite = 1'b0;
        curCache = 1'b0;
        curExt = '0;
        prevEn = 1'b0;
        prevBusy = 1'b0;
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(negedge clk);
        if (busy !== 1'b0 || extEn !== 1'b0 || extOen !== 1'b1 || progress !== '0) begin
            $display("FAIL %0t: outputs not idle after reset", $time);
            flowErrors++;
        end

        for (int p = 0; p < NumPairs; p++) begin
            cache = 1'(randBits(1));
            sAddr = 10'(randBits(10));
            eA = 30'(randBits(30));
            eB = 30'(randBits(30));
            len = refBurstLen(cache);
            coreRead(cache, sAddr - 10'd1, before0);
            coreRead(cache, sAddr + 10'(len), before1);

            runRequest(1'b0, cache, sAddr, eA);
            for (int k = 0; k < len; k++) begin
                coreRead(cache, sAddr + 10'(k), got);
                if (got !== refWord(eA + 30'(k))) begin
                    $display("FAIL %0t: cache %0d word %0d is %h, expected %h", $time,
                             cache, k, got, refWord(eA + 30'(k)));
                    flowErrors++;
                end
                shadow[cache][sAddr + 10'(k)] = refWord(eA + 30'(k));
            end
            coreRead(cache, sAddr - 10'd1, got);
            if (got !== before0) begin
                $display("FAIL %0t: word below the burst changed", $time);
                flowErrors++;
            end
            coreRead(cache, sAddr + 10'(len), got);
            if (got !== before1) begin
                $display("FAIL %0t: word above the burst changed", $time);
                flowErrors++;
            end

            runRequest(1'b1, cache, sAddr, eB);
            if (u_mem.writeCount != len) begin
                $display("FAIL %0t: %0d words written, expected %0d", $time,
                         u_mem.writeCount, len);
                flowErrors++;
            end
            for (int k = 0; k < len; k++) begin
                expMem[eB + 30'(k)] = shadow[cache][sAddr + 10'(k)];
                if (u_mem.peek(eB + 30'(k)) !== refWord(eB + 30'(k))) begin
                    $display("FAIL %0t: writeback word %0d is %h, expected %h", $time, k,
                             u_mem.peek(eB + 30'(k)), refWord(eB + 30'(k)));
                    flowErrors++;
                end
            end
        end

        if (u_mem.headerCount != expectedHeaders) begin
            $display("FAIL %0t: %0d headers seen, expected %0d", $time,
                     u_mem.headerCount, expectedHeaders);
            flowErrors++;
        end
        $display("Errors: %0d in checks, %0d in monitor", flowErrors, monErrors);
        if (flowErrors + monErrors == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

//--- tests/ExtMemModel.sv
`timescale 1ns/1ns

module ExtMemModel (
    input  logic        clk,
    input  logic        extEn,
    input  logic        extOen,
    input  logic [31:0] extBusOut,
    output logic [31:0] extBusIn
);

    logic [31:0] mem [logic [29:0]];
    logic        active;
    logic        isWrite;
    logic [29:0] base;
    int          idx;
    int          readIdx;
    int          headerCount;
    int          writeCount;

    function automatic logic [31:0] patternWord(input logic [29:0] a);
        return {a, 2'b10} ^ {~a[13:0], a[29:12]};
    endfunction

    // Unwritten words read back as the preload pattern
    function automatic logic [31:0] peek(input logic [29:0] a);
        return mem.exists(a) ? mem[a] : patternWord(a);
    endfunction

    initial begin
        extBusIn = '0;
        active = 1'b0;
        headerCount = 0;
        writeCount = 0;
    end

    always @(posedge clk) begin
        if (extEn && !active) begin
            // First extEn cycle carries the header
            active = 1'b1;
            isWrite = extBusOut[31];
            base = extBusOut[29:0];
            idx = 1;
            readIdx = 0;
            writeCount = 0;
            headerCount = headerCount + 1;
        end else if (extEn && isWrite) begin
            if (idx >= 3) begin
                mem[base + 30'(idx - 3)] = extBusOut;
                writeCount = writeCount + 1;
            end
            idx = idx + 1;
        end else if (extEn && !extOen) begin
            extBusIn <= peek(base + 30'(readIdx));
            readIdx = readIdx + 1;
        end else if (!extEn) begin
            active = 1'b0;
        end
    end

endmodule

//--- src/MemorySubsystem.sv
`timescale 1ns/1ns
`include "memctrl_macros.svh"

module MemorySubsystem (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        reqStrobe,
    input  logic                        reqWrite,
    input  logic                        reqCacheId,
    input  logic [`MEMCTRL_SRAM_AW-1:0] reqSramAddr,
    input  logic [`MEMCTRL_EXT_AW-1:0]  reqExtAddr,
    output logic                        busy,
    output logic [`MEMCTRL_SRAM_AW-1:0] progress,
    output logic                        extEn,
    output logic                        extOen,
    output logic [31:0]                 extBusOut,
    input  logic [31:0]                 extBusIn,
    input  logic [`MEMCTRL_SRAM_AW-1:0] coreAddr0,
    output logic [31:0]                 coreData0,
    input  logic [`MEMCTRL_SRAM_AW-1:0] coreAddr1,
    output logic [31:0]                 coreData1
);

    import MemCtrlPkg::*;

    logic                        accept;
    memRequest_t                 req;
    logic [`MEMCTRL_SRAM_AW-1:0] burstLen;
    logic [31:0]                 header;

    sramPort_t   sramPort0;
    sramPort_t   sramPort1;
    logic [31:0] rdData0;
    logic [31:0] rdData1;

    logic        sendHeader;
    logic        sendData;
    logic [31:0] dataWord;
    logic        busRelease;
    logic        oenLow;

    RequestLatch requestLatch (
        .clk        (clk),
        .rst        (rst),
        .reqStrobe  (reqStrobe),
        .reqWrite   (reqWrite),
        .reqCacheId (reqCacheId),
        .reqSramAddr(reqSramAddr),
        .reqExtAddr (reqExtAddr),
        .busy       (busy),
        .accept     (accept),
        .req        (req),
        .burstLen   (burstLen),
        .header     (header)
    );

    BurstSequencer burstSequencer (
        .clk       (clk),
        .rst       (rst),
        .accept    (accept),
        .req       (req),
        .burstLen  (burstLen),
        .rdData0   (rdData0),
        .rdData1   (rdData1),
        .extBusIn  (extBusIn),
        .busy      (busy),
        .progress  (progress),
        .sramPort0 (sramPort0),
        .sramPort1 (sramPort1),
        .sendHeader(sendHeader),
        .sendData  (sendData),
        .dataWord  (dataWord),
        .busRelease(busRelease),
        .oenLow    (oenLow)
    );

    // Instruction cache
    CacheSram icache (
        .clk     (clk),
        .port    (sramPort0),
        .coreAddr(coreAddr0),
        .rdData  (rdData0),
        .coreData(coreData0)
    );

    // Data cache
    CacheSram dcache (
        .clk     (clk),
        .port    (sramPort1),
        .coreAddr(coreAddr1),
        .rdData  (rdData1),
        .coreData(coreData1)
    );

    ExtBusDriver extBusDriver (
        .clk       (clk),
        .rst       (rst),
        .sendHeader(sendHeader),
        .header    (header),
        .sendData  (sendData),
        .dataWord  (dataWord),
        .busRelease(busRelease),
        .oenLow    (oenLow),
        .extEn     (extEn),
        .extOen    (extOen),
        .extBusOut (extBusOut)
    );

endmodule

//--- src/ExtBusDriver.sv
`timescale 1ns/1ns

module ExtBusDriver (
    input  logic        clk,
    input  logic        rst,
    input  logic        sendHeader,
    input  logic [31:0] header,
    input  logic        sendData,
    input  logic [31:0] dataWord,
    input  logic        busRelease,
    input  logic        oenLow,
    output logic        extEn,
    output logic        extOen,
    output logic [31:0] extBusOut
);

    always_ff @(posedge clk) begin
        if (rst) begin
            extEn     <= 1'b0;
            extOen    <= 1'b1;
            extBusOut <= '0;
        end else begin
            extOen <= !oenLow;
            if (sendHeader) begin
                extEn     <= 1'b1;
                extBusOut <= header;
            end else if (busRelease) begin
                extEn     <= 1'b0;
                extBusOut <= '0;
            end else if (sendData) begin
                extBusOut <= dataWord;
            end
        end
    end

endmodule

//--- src/CacheSram.sv
`timescale 1ns/1ns
`include "memctrl_macros.svh"

module CacheSram (
    input  logic                        clk,
    input  MemCtrlPkg::sramPort_t       port,
    input  logic [`MEMCTRL_SRAM_AW-1:0] coreAddr,
    output logic [31:0]                 rdData,
    output logic [31:0]                 coreData
);

    logic [31:0] mem [0:(1 << `MEMCTRL_SRAM_AW)-1];

    // Controller port, full-word writes
    always_ff @(posedge clk) begin
        if (port.en) begin
            if (port.wr) begin
                mem[port.addr] <= port.data;
            end else begin
                rdData <= mem[port.addr];
            end
        end
    end

    // Core read port
    always_ff @(posedge clk) begin
        coreData <= mem[coreAddr];
    end

endmodule

//--- src/BurstSequencer.sv
`timescale 1ns/1ns
`include "memctrl_macros.svh"

module BurstSequencer (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        accept,
    input  MemCtrlPkg::memRequest_t     req,
    input  logic [`MEMCTRL_SRAM_AW-1:0] burstLen,
    input  logic [31:0]                 rdData0,
    input  logic [31:0]                 rdData1,
    input  logic [31:0]                 extBusIn,
    output logic                        busy,
    output logic [`MEMCTRL_SRAM_AW-1:0] progress,
    output MemCtrlPkg::sramPort_t       sramPort0,
    output MemCtrlPkg::sramPort_t       sramPort1,
    output logic                        sendHeader,
    output logic                        sendData,
    output logic [31:0]                 dataWord,
    output logic                        busRelease,
    output logic                        oenLow
);

    import MemCtrlPkg::*;

    seqState_t state;

    logic [2:0]                  waitCnt;
    logic [`MEMCTRL_SRAM_AW-1:0] wordCnt;
    logic [`MEMCTRL_SRAM_AW-1:0] sramAddr;

    logic                        portEn;
    logic                        portWr;
    logic [`MEMCTRL_SRAM_AW-1:0] portAddr;
    logic [31:0]                 portData;
    sramPort_t                   port;

    logic rdValid;
    logic issue;
    logic readDone;
    logic writeDone;

    // Extra cycle after the last capture so progress peaks at the burst length
    assign readDone = (state == SeqReadBurst) && (wordCnt == burstLen);

    // Two words still in flight after the last SRAM read
    assign writeDone = (state == SeqWriteBurst) &&
                       (wordCnt == burstLen + `MEMCTRL_SRAM_AW'(2));

    assign issue = ((state == SeqReadBurst) && !readDone) ||
                   ((state == SeqWriteBurst) && (wordCnt < burstLen));

    assign busy       = (state != SeqIdle);
    assign sendHeader = accept && (state == SeqIdle);
    assign busRelease = readDone || writeDone;
    assign sendData   = rdValid;

    // oen goes low two cycles before the first data word
    assign oenLow = ((state == SeqReadWait) && (waitCnt < 3'd2)) ||
                    ((state == SeqReadBurst) && !readDone);

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= SeqIdle;
            waitCnt  <= '0;
            wordCnt  <= '0;
            progress <= '0;
            portEn   <= 1'b0;
            portWr   <= 1'b0;
            rdValid  <= 1'b0;
        end else begin
            portEn  <= issue;
            portWr  <= (state == SeqReadBurst);
            // SRAM read data arrives one cycle after the strobe
            rdValid <= portEn && !portWr;
            case (state)
                SeqIdle: begin
                    if (accept) begin
                        state   <= req.write ? SeqWriteBurst : SeqReadWait;
                        waitCnt <= `MEMCTRL_READ_WAIT;
                        wordCnt <= '0;
                    end
                end
                SeqReadWait: begin
                    waitCnt <= waitCnt - 3'd1;
                    if (waitCnt == 3'd0) begin
                        state <= SeqReadBurst;
                    end
                end
                SeqReadBurst: begin
                    if (readDone) begin
                        state    <= SeqIdle;
                        progress <= '0;
                    end else begin
                        wordCnt  <= wordCnt + 1'b1;
                        progress <= progress + 1'b1;
                    end
                end
                SeqWriteBurst: begin
                    if (writeDone) begin
                        state <= SeqIdle;
                    end else begin
                        wordCnt <= wordCnt + 1'b1;
                    end
                end
                default: state <= SeqIdle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (sendHeader) begin
            sramAddr <= req.sramAddr;
        end else if (issue) begin
            sramAddr <= sramAddr + 1'b1;
        end
        portAddr <= sramAddr;
        portData <= extBusIn;
    end

    assign port = {portEn, portWr, portAddr, portData};

    // Only the selected cache sees the strobe
    assign sramPort0 = req.cacheId ? '0 : port;
    assign sramPort1 = req.cacheId ? port : '0;

    assign dataWord = req.cacheId ? rdData1 : rdData0;

endmodule

//--- src/RequestLatch.sv
`timescale 1ns/1ns
`include "memctrl_macros.svh"

module RequestLatch (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        reqStrobe,
    input  logic                        reqWrite,
    input  logic                        reqCacheId,
    input  logic [`MEMCTRL_SRAM_AW-1:0] reqSramAddr,
    input  logic [`MEMCTRL_EXT_AW-1:0]  reqExtAddr,
    input  logic                        busy,
    output logic                        accept,
    output MemCtrlPkg::memRequest_t     req,
    output logic [`MEMCTRL_SRAM_AW-1:0] burstLen,
    output logic [31:0]                 header
);

    logic take;

    // Accept is still high the cycle before busy rises
    assign take = reqStrobe && !busy && !accept;

    always_ff @(posedge clk) begin
        if (rst) begin
            accept <= 1'b0;
        end else begin
            accept <= take;
        end
    end

    always_ff @(posedge clk) begin
        if (take) begin
            req.write    <= reqWrite;
            req.cacheId  <= reqCacheId;
            req.sramAddr <= reqSramAddr;
            req.extAddr  <= reqExtAddr;
        end
    end

    assign burstLen = req.cacheId ? `MEMCTRL_BURST_DCACHE : `MEMCTRL_BURST_ICACHE;

    // Write flag, cache id, word address
    assign header = {req.write, req.cacheId, req.extAddr};

endmodule

//--- src/MemCtrlPkg.sv
`include "memctrl_macros.svh"

package MemCtrlPkg;

    // One refill or writeback request
    typedef struct packed {
        logic                        write;
        logic                        cacheId;
        logic [`MEMCTRL_SRAM_AW-1:0] sramAddr;
        logic [`MEMCTRL_EXT_AW-1:0]  extAddr;
    } memRequest_t;

    // Controller side of a cache SRAM, both strobes active high
    typedef struct packed {
        logic                        en;
        logic                        wr;
        logic [`MEMCTRL_SRAM_AW-1:0] addr;
        logic [31:0]                 data;
    } sramPort_t;

    typedef enum logic [1:0] {
        SeqIdle,
        SeqReadWait,
        SeqWriteBurst,
        SeqReadBurst
    } seqState_t;

endpackage

//--- src/memctrl_macros.svh
`ifndef MEMCTRL_MACROS_SVH
`define MEMCTRL_MACROS_SVH

// Burst length in words per cache
`define MEMCTRL_BURST_ICACHE 10'd64
`define MEMCTRL_BURST_DCACHE 10'd128

// Cycles from the header to the fall of oen on a read
`define MEMCTRL_READ_WAIT 3'd4

// Word-address widths
`define MEMCTRL_SRAM_AW 10
`define MEMCTRL_EXT_AW 30

`endif
